// File: gpio_periph.f
+incdir+hw
hw/gpio_pkg.sv
hw/gpio_decode.sv
hw/gpio_execute.sv
hw/gpio_result.sv
hw/gpio_periph.sv
dv/gpio_periph_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

top=gpio_periph_tb
obj=obj_dir

verilator --binary --timing --assert \
  --top-module "$top" \
  --Mdir "$obj" \
  -o "$top" \
  -f gpio_periph.f \
  || { echo "build failed"; exit 1; }

out=$("./$obj/$top" 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "All checks passed" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: dv/gpio_periph_tb.sv
`default_nettype none
`include "gpio_cfg.svh"

module gpio_periph_tb;

  typedef logic [`GPIO_ADDR_W-1:0] addr_t;
  typedef logic [`GPIO_DATA_W-1:0] data_t;
  typedef logic [`GPIO_REG_W-1:0]  reg_t;

  localparam int          CLK_PERIOD   = 100;
  localparam int          DRIVE_DLY    = 10;
  localparam int          RESET_CYCLES = 16;
  localparam int          N_ROUNDS     = 10;
  // each round issues eight transactions, plus the first read after reset
  localparam int          N_TRANS      = 8 * N_ROUNDS + 1;
  localparam int          CYCLE_LIMIT  = 40 * N_TRANS + RESET_CYCLES;
  localparam logic [31:0] SEED         = 32'hc42a;

  logic  clk;
  logic  rst;
  logic  awvalid;
  addr_t awaddr;
  logic  wvalid;
  data_t wdata;
  logic  arvalid;
  addr_t araddr;
  logic  rready;
  reg_t  gpio_in;
  logic  awready;
  logic  wready;
  logic  bvalid;
  logic  arready;
  logic  rvalid;
  logic  rlast;
  data_t rdata;
  reg_t  csr;
  logic  print_valid;
  reg_t  print_char;

  // reference model state, one step per clock at the falling edge
  reg_t        char_q[$];
  reg_t        m_csr      = '0;
  data_t       m_rdata    = '0;
  logic        m_wr_pend  = 1'b0;
  logic        m_wr_csr   = 1'b0;
  logic        m_wr_print = 1'b0;
  logic        m_rd_req   = 1'b0;
  logic        m_rd_csr   = 1'b0;
  logic        m_rd_in    = 1'b0;
  logic        m_rvalid   = 1'b0;
  logic        m_bvalid   = 1'b0;
  logic        m_pv       = 1'b0;
  logic        m_ports_on = 1'b0;
  int unsigned cycles     = 0;

  gpio_periph u_dut (
    .clk         (clk),
    .rst         (rst),
    .awvalid     (awvalid),
    .awaddr      (awaddr),
    .wvalid      (wvalid),
    .wdata       (wdata),
    .arvalid     (arvalid),
    .araddr      (araddr),
    .rready      (rready),
    .gpio_in     (gpio_in),
    .awready     (awready),
    .wready      (wready),
    .bvalid      (bvalid),
    .arready     (arready),
    .rvalid      (rvalid),
    .rlast       (rlast),
    .rdata       (rdata),
    .csr         (csr),
    .print_valid (print_valid),
    .print_char  (print_char)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_violation(input string msg);
    $display("Fail at time %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_mismatch(input string name, input data_t exp_val, input data_t act_val);
    $display("Fail at time %0t: %s expected 0x%0h got 0x%0h", $time, name, exp_val, act_val);
    abort_run();
  endtask

  task automatic check_value(input string name, input data_t exp_val, input data_t act_val);
    assert (act_val === exp_val) else report_mismatch(name, exp_val, act_val);
  endtask

  task automatic finish_run();
    if (char_q.size() != 0) begin
      report_violation("console characters were written but never strobed");
    end else begin
      $display("All checks passed");
      $finish;
    end
  endtask

  // inputs only ever change a short delay after the rising edge
  task automatic next_drive();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  function automatic addr_t pick_unmapped();
    addr_t addr;
    addr = addr_t'($urandom);
    if (addr == `GPIO_OFS_CSR || addr == `GPIO_OFS_IN || addr == `GPIO_OFS_PRINT) begin
      addr = addr ^ addr_t'(16'h0100);
    end
    return addr;
  endfunction

  task automatic write_reg(input addr_t addr, input data_t data);
    int   gap;
    logic seen;
    gap = int'($urandom_range(0, 2));
    awvalid = 1'b1;
    awaddr  = addr;
    do begin
      @(negedge clk);
      seen = awready;
      next_drive();
    end while (!seen);
    awvalid = 1'b0;
    repeat (gap) next_drive();
    wvalid = 1'b1;
    wdata  = data;
    do begin
      @(negedge clk);
      seen = wready;
      next_drive();
    end while (!seen);
    wvalid = 1'b0;
    wdata  = data_t'($urandom);
  endtask

  task automatic write_print(input reg_t ch);
    data_t data;
    data = data_t'($urandom);
    data[`GPIO_REG_W-1:0] = ch;
    char_q.push_back(ch);
    write_reg(`GPIO_OFS_PRINT, data);
  endtask

  // a stall of zero keeps rready high before the beat shows up
  task automatic read_reg(input addr_t addr, output data_t data);
    int   stall;
    logic seen;
    stall = int'($urandom_range(0, 3));
    arvalid = 1'b1;
    araddr  = addr;
    do begin
      @(negedge clk);
      seen = arready;
      next_drive();
    end while (!seen);
    arvalid = 1'b0;
    if (stall == 0) rready = 1'b1;
    do begin
      @(negedge clk);
      seen = rvalid;
      data = rdata;
      next_drive();
    end while (!seen);
    if (stall != 0) begin
      repeat (stall - 1) next_drive();
      rready = 1'b1;
      next_drive();
    end
    rready = 1'b0;
  endtask

  task automatic read_gpio();
    reg_t  level;
    data_t got;
    level = reg_t'($urandom);
    gpio_in = level;
    repeat (3) next_drive();
    read_reg(`GPIO_OFS_IN, got);
    check_value("rdata", data_t'(level), got);
  endtask

  initial begin
    data_t got;
    void'($urandom(SEED));
    rst     = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    gpio_in = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b1;
    next_drive();
    read_reg(`GPIO_OFS_CSR, got);
    check_value("rdata", '0, got);
    for (int i = 0; i < N_ROUNDS; i++) begin
      write_reg(`GPIO_OFS_CSR, data_t'($urandom));
      read_reg(`GPIO_OFS_CSR, got);
      write_print(reg_t'($urandom));
      write_reg(pick_unmapped(), data_t'($urandom));
      read_gpio();
      read_reg(pick_unmapped(), got);
      check_value("rdata", '0, got);
      fork
        write_reg(`GPIO_OFS_CSR, data_t'($urandom));
        read_reg(`GPIO_OFS_CSR, got);
      join
    end
    repeat (4) next_drive();
    finish_run();
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      report_violation("timeout, the DUT stopped answering");
    end
  end

  // outputs are compared with the model where they are settled
  always @(negedge clk) begin
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic r_hs;
    if (rst) begin
      check_value("csr", data_t'(m_csr), data_t'(csr));
      check_value("awready", data_t'(m_ports_on && !m_wr_pend), data_t'(awready));
      check_value("wready", data_t'(wvalid && m_wr_pend), data_t'(wready));
      check_value("arready", data_t'(m_ports_on && !m_rd_req && !m_rvalid), data_t'(arready));
      check_value("bvalid", data_t'(m_bvalid), data_t'(bvalid));
      check_value("print_valid", data_t'(m_pv), data_t'(print_valid));
      check_value("rvalid", data_t'(m_rvalid), data_t'(rvalid));
      check_value("rlast", data_t'(m_rvalid), data_t'(rlast));
      if (m_rvalid) check_value("rdata", m_rdata, rdata);
      if (print_valid) begin
        if (char_q.size() == 0) begin
          report_violation("console strobe with no character expected");
        end else begin
          check_value("print_char", data_t'(char_q.pop_front()), data_t'(print_char));
        end
      end

      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      ar_hs = arvalid && arready;
      r_hs  = rvalid && rready;

      // read data is frozen from the csr value before this edge's write lands
      if (m_rd_req) begin
        m_rdata = '0;
        if (m_rd_csr) m_rdata = data_t'(m_csr);
        if (m_rd_in) m_rdata = data_t'(gpio_in);
      end
      if (m_rd_req) m_rvalid = 1'b1;
      else if (r_hs) m_rvalid = 1'b0;
      m_rd_req = ar_hs;
      if (ar_hs) begin
        m_rd_csr = (araddr == `GPIO_OFS_CSR);
        m_rd_in  = (araddr == `GPIO_OFS_IN);
      end

      m_bvalid = w_hs;
      m_pv     = w_hs && m_wr_print;
      if (w_hs && m_wr_csr) m_csr = wdata[`GPIO_REG_W-1:0];
      if (aw_hs) begin
        m_wr_pend  = 1'b1;
        m_wr_csr   = (awaddr == `GPIO_OFS_CSR);
        m_wr_print = (awaddr == `GPIO_OFS_PRINT);
      end else if (w_hs) begin
        m_wr_pend = 1'b0;
      end
      m_ports_on = 1'b1;
    end
  end

  a_bvalid_pulse: assert property (
    @(posedge clk) disable iff (!rst)
    (wvalid && wready) |=> bvalid ##1 !bvalid
  ) else report_violation("bvalid was not a single pulse after the write handshake");

  a_print_pulse: assert property (
    @(posedge clk) disable iff (!rst)
    print_valid |=> !print_valid
  ) else report_violation("print_valid stayed high for more than one cycle");

  a_read_latency: assert property (
    @(posedge clk) disable iff (!rst)
    (arvalid && arready) |=> !rvalid ##1 rvalid
  ) else report_violation("rvalid did not rise two cycles after the read handshake");

  a_read_hold: assert property (
    @(posedge clk) disable iff (!rst)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && !arready)
  ) else report_violation("read beat changed or dropped before rready");

  a_read_beat: assert property (
    @(posedge clk) disable iff (!rst)
    rvalid |-> (rlast && !arready)
  ) else report_violation("rlast low or arready high during a read beat");

endmodule

`default_nettype wire

// File: hw/gpio_periph.sv
`default_nettype none
`include "gpio_cfg.svh"

module gpio_periph (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    awvalid,
  input  logic [`GPIO_ADDR_W-1:0] awaddr,
  input  logic                    wvalid,
  input  logic [`GPIO_DATA_W-1:0] wdata,
  input  logic                    arvalid,
  input  logic [`GPIO_ADDR_W-1:0] araddr,
  input  logic                    rready,
  input  logic [`GPIO_REG_W-1:0]  gpio_in,
  output logic                    awready,
  output logic                    wready,
  output logic                    bvalid,
  output logic                    arready,
  output logic                    rvalid,
  output logic                    rlast,
  output logic [`GPIO_DATA_W-1:0] rdata,
  output logic [`GPIO_REG_W-1:0]  csr,
  output logic                    print_valid,
  output logic [`GPIO_REG_W-1:0]  print_char
);
  import gpio_pkg::*;

  logic                   wr_pend;
  periph_op_e             wr_op;
  logic                   wr_done;
  logic                   rd_req;
  periph_op_e             rd_op;
  logic                   rd_busy;
  logic [`GPIO_REG_W-1:0] csr_q;
  logic [`GPIO_REG_W-1:0] gpio_sync;

  // address channels
  gpio_decode u_decode (
    .clk     (clk),
    .rst     (rst),
    .awvalid (awvalid),
    .awaddr  (awaddr),
    .arvalid (arvalid),
    .araddr  (araddr),
    .wr_done (wr_done),
    .rd_busy (rd_busy),
    .awready (awready),
    .arready (arready),
    .wr_pend (wr_pend),
    .wr_op   (wr_op),
    .rd_req  (rd_req),
    .rd_op   (rd_op)
  );

  // write data, register state and input pins
  gpio_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .wvalid      (wvalid),
    .wdata       (wdata),
    .wr_pend     (wr_pend),
    .wr_op       (wr_op),
    .gpio_in     (gpio_in),
    .wready      (wready),
    .wr_done     (wr_done),
    .csr_q       (csr_q),
    .print_valid (print_valid),
    .print_char  (print_char),
    .gpio_sync   (gpio_sync)
  );

  // write response and read data
  gpio_result u_result (
    .clk       (clk),
    .rst       (rst),
    .wr_done   (wr_done),
    .rd_req    (rd_req),
    .rd_op     (rd_op),
    .csr_q     (csr_q),
    .gpio_sync (gpio_sync),
    .rready    (rready),
    .bvalid    (bvalid),
    .rvalid    (rvalid),
    .rlast     (rlast),
    .rdata     (rdata),
    .rd_busy   (rd_busy)
  );

  assign csr = csr_q;

endmodule

`default_nettype wire

// File: hw/gpio_result.sv
`default_nettype none
`include "gpio_cfg.svh"

module gpio_result (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wr_done,
  input  logic                    rd_req,
  input  gpio_pkg::periph_op_e    rd_op,
  input  logic [`GPIO_REG_W-1:0]  csr_q,
  input  logic [`GPIO_REG_W-1:0]  gpio_sync,
  input  logic                    rready,
  output logic                    bvalid,
  output logic                    rvalid,
  output logic                    rlast,
  output logic [`GPIO_DATA_W-1:0] rdata,
  output logic                    rd_busy
);
  import gpio_pkg::*;

  rd_state_e              state_q;
  rd_state_e              state_d;
  logic [`GPIO_DATA_W-1:0] rd_word;

  // write response is a single pulse and the master never acknowledges it
  always_ff @(posedge clk) begin
    if (!rst) begin
      bvalid <= 1'b0;
    end else begin
      bvalid <= wr_done;
    end
  end

  // zero extended read value for the pending operation
  always_comb begin
    rd_word = '0;
    case (rd_op)
      op_csr:     rd_word[`GPIO_REG_W-1:0] = csr_q;
      op_gpio_in: rd_word[`GPIO_REG_W-1:0] = gpio_sync;
      default:    rd_word = '0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      rd_idle:  if (rd_req) state_d = rd_valid;
      rd_valid: if (rready) state_d = rd_idle;
      default:  state_d = rd_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q <= rd_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // data is frozen here so a later csr write cannot disturb a held beat
  always_ff @(posedge clk) begin
    if (rd_req) begin
      rdata <= rd_word;
    end
  end

  // every read is a single beat, so rlast follows rvalid
  assign rvalid  = (state_q == rd_valid);
  assign rlast   = rvalid;
  assign rd_busy = rvalid;

  a_rdata_stable: assert property (
    @(posedge clk) disable iff (!rst)
    (rvalid && !rready) |=> (rvalid && $stable(rdata))
  );

endmodule

`default_nettype wire

// File: hw/gpio_execute.sv
`default_nettype none
`include "gpio_cfg.svh"

module gpio_execute (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wvalid,
  input  logic [`GPIO_DATA_W-1:0] wdata,
  input  logic                    wr_pend,
  input  gpio_pkg::periph_op_e    wr_op,
  input  logic [`GPIO_REG_W-1:0]  gpio_in,
  output logic                    wready,
  output logic                    wr_done,
  output logic [`GPIO_REG_W-1:0]  csr_q,
  output logic                    print_valid,
  output logic [`GPIO_REG_W-1:0]  print_char,
  output logic [`GPIO_REG_W-1:0]  gpio_sync
);
  import gpio_pkg::*;

  logic                   w_hs;
  logic                   csr_wr;
  logic                   print_wr;
  logic [`GPIO_REG_W-1:0] wr_byte;
  logic [`GPIO_REG_W-1:0] gpio_meta;

  // write data is only taken once decode holds an address for it
  assign wready  = wvalid && wr_pend;
  assign w_hs    = wvalid && wready;
  assign wr_done = w_hs;

  assign wr_byte  = wdata[`GPIO_REG_W-1:0];
  assign csr_wr   = w_hs && (wr_op == op_csr);
  assign print_wr = w_hs && (wr_op == op_print);

  // control register
  // writes to gpio_in or unmapped offsets fall through and change nothing
  always_ff @(posedge clk) begin
    if (!rst) begin
      csr_q <= '0;
    end else if (csr_wr) begin
      csr_q <= wr_byte;
    end
  end

  // console strobe is high for the cycle after the write handshake
  always_ff @(posedge clk) begin
    if (!rst) begin
      print_valid <= 1'b0;
    end else begin
      print_valid <= print_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (print_wr) begin
      print_char <= wr_byte;
    end
  end

  // two flop synchronizer for the asynchronous input pins
  always_ff @(posedge clk) begin
    gpio_meta <= gpio_in;
    gpio_sync <= gpio_meta;
  end

  // decode drops wr_pend after each handshake so console writes never land back to back
  a_print_single: assert property (
    @(posedge clk) disable iff (!rst)
    print_valid |=> !print_valid
  );

endmodule

`default_nettype wire

// File: hw/gpio_decode.sv
`default_nettype none
`include "gpio_cfg.svh"

module gpio_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    awvalid,
  input  logic [`GPIO_ADDR_W-1:0] awaddr,
  input  logic                    arvalid,
  input  logic [`GPIO_ADDR_W-1:0] araddr,
  input  logic                    wr_done,
  input  logic                    rd_busy,
  output logic                    awready,
  output logic                    arready,
  output logic                    wr_pend,
  output gpio_pkg::periph_op_e    wr_op,
  output logic                    rd_req,
  output gpio_pkg::periph_op_e    rd_op
);
  import gpio_pkg::*;

  logic ports_en;
  logic aw_hs;
  logic ar_hs;

  // map an address onto the register it selects
  function automatic periph_op_e classify(input logic [`GPIO_ADDR_W-1:0] addr);
    periph_op_e op;
    case (addr)
      `GPIO_OFS_CSR:   op = op_csr;
      `GPIO_OFS_IN:    op = op_gpio_in;
      `GPIO_OFS_PRINT: op = op_print;
      default:         op = op_none;
    endcase
    return op;
  endfunction

  // both address channels stay closed for the reset cycle
  always_ff @(posedge clk) begin
    if (!rst) begin
      ports_en <= 1'b0;
    end else begin
      ports_en <= 1'b1;
    end
  end

  // a pending address is never overwritten by a second one
  assign awready = ports_en && !wr_pend;
  assign arready = ports_en && !rd_req && !rd_busy;

  assign aw_hs = awvalid && awready;
  assign ar_hs = arvalid && arready;

  // write address side
  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_pend <= 1'b0;
    end else if (aw_hs) begin
      wr_pend <= 1'b1;
    end else if (wr_done) begin
      wr_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_op <= classify(awaddr);
    end
  end

  // read address side, rd_req lasts one cycle and result takes over from there
  always_ff @(posedge clk) begin
    if (!rst) begin
      rd_req <= 1'b0;
    end else begin
      rd_req <= ar_hs;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_op <= classify(araddr);
    end
  end

  // execute may only complete a write that this stage opened
  a_done_needs_pend: assert property (
    @(posedge clk) disable iff (!rst)
    wr_done |-> wr_pend
  );

  // result must take the request so that arready stays low until rready
  a_req_makes_busy: assert property (
    @(posedge clk) disable iff (!rst)
    rd_req |=> rd_busy
  );

endmodule

`default_nettype wire

// File: hw/gpio_pkg.sv
`default_nettype none

package gpio_pkg;

  // operation that a decoded bus address selects
  // op_none covers every offset outside the register map
  typedef enum logic [1:0] {
    op_none    = 2'd0,
    op_csr     = 2'd1,
    op_gpio_in = 2'd2,
    op_print   = 2'd3
  } periph_op_e;

  // read channel state in the result stage
  // rd_valid holds the data beat until the master takes it
  typedef enum logic {
    rd_idle  = 1'b0,
    rd_valid = 1'b1
  } rd_state_e;

endpackage

`default_nettype wire

// File: hw/gpio_cfg.svh
`ifndef GPIO_CFG_SVH
`define GPIO_CFG_SVH

// only the low address bits take part in register decode
`define GPIO_ADDR_W 16

// width of the write and read data channels
`define GPIO_DATA_W 32

// control register, input port and console character all share this width
`define GPIO_REG_W 8

// register map

// output control register, read and write
`define GPIO_OFS_CSR 16'h0000

// synchronized view of the input pins, read only
`define GPIO_OFS_IN 16'h0004

// console character port, write only
`define GPIO_OFS_PRINT 16'h0008

`endif
